// File: rvfi_params.svh
/*
  RVFI tracer parameters
  Widths, table depth, port count and the environment call causes
  shared by the tracer package and its stages
*/

`ifndef RVFI_PARAMS_SVH
`define RVFI_PARAMS_SVH

// ------------------------------
// Datapath widths
// ------------------------------
`define RVFI_XLEN            32  // Data width
`define RVFI_VLEN            32  // Address and PC width
`define RVFI_BE_BITS         4   // Byte enables per XLEN word
`define RVFI_REG_ADDR_BITS   5

// ------------------------------
// Scoreboard and commit
// ------------------------------
`define RVFI_NR_SB_ENTRIES   8
`define RVFI_TRANS_ID_BITS   3   // Index into the scoreboard
`define RVFI_NR_COMMIT_PORTS 2

// Environment call causes, these still retire
`define RVFI_CAUSE_ECALL_U   8
`define RVFI_CAUSE_ECALL_S   9
`define RVFI_CAUSE_ECALL_M   11

`endif

// File: rvfi_pkg.sv
/*
  RVFI tracer types
  Probe bundles observed on the core, the scoreboard side table entry
  and the retirement record handed out per commit port
*/

`include "rvfi_params.svh"

package rvfi_pkg;

  // ------------------------------
  // Enums
  // ------------------------------
  typedef enum logic [1:0] {
    FU_NONE  = 2'd0,
    FU_LOAD  = 2'd1,
    FU_STORE = 2'd2,
    FU_OTHER = 2'd3
  } fu_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  typedef enum logic {
    SLOT_EMPTY = 1'b0,
    SLOT_FULL  = 1'b1
  } slot_state_e;

  // ------------------------------
  // Probes from the core
  // ------------------------------
  typedef struct packed {
    logic                  valid;
    logic [`RVFI_XLEN-1:0] instr;
    logic                  is_compressed;
  } fetch_probe_t;

  typedef struct packed {
    logic                           decoded_valid;
    logic                           decoded_ack;
    logic                           flush_unissued;
    logic [`RVFI_TRANS_ID_BITS-1:0] issue_ptr;
    logic                           issue_instr_ack;
    logic                           flush;
    logic [`RVFI_XLEN-1:0]          rs1_fwd;  // Forwarded operands at issue
    logic [`RVFI_XLEN-1:0]          rs2_fwd;
  } issue_probe_t;

  typedef struct packed {
    fu_e                            fu;
    logic [`RVFI_VLEN-1:0]          vaddr;
    logic [`RVFI_BE_BITS-1:0]       be;
    logic [`RVFI_TRANS_ID_BITS-1:0] trans_id;
    logic [`RVFI_XLEN-1:0]          wdata;    // Store data
  } lsu_probe_t;

  typedef struct packed {
    logic                           valid;
    logic                           ack;
    logic [`RVFI_TRANS_ID_BITS-1:0] ptr;
    logic [`RVFI_VLEN-1:0]          pc;
    logic [`RVFI_REG_ADDR_BITS-1:0] rs1;
    logic [`RVFI_REG_ADDR_BITS-1:0] rs2;
    logic [`RVFI_REG_ADDR_BITS-1:0] rd;
    logic [`RVFI_XLEN-1:0]          result;
    logic [`RVFI_XLEN-1:0]          wdata;
  } commit_probe_t;

  typedef struct packed {
    logic                  valid;
    logic [`RVFI_XLEN-1:0] cause;
  } trap_probe_t;

  // ------------------------------
  // Tracer internal and output
  // ------------------------------
  typedef struct packed {
    logic [`RVFI_XLEN-1:0]    rs1_rdata;
    logic [`RVFI_XLEN-1:0]    rs2_rdata;
    logic [`RVFI_VLEN-1:0]    mem_addr;
    logic [`RVFI_BE_BITS-1:0] mem_rmask;
    logic [`RVFI_BE_BITS-1:0] mem_wmask;
    logic [`RVFI_XLEN-1:0]    mem_wdata;
    logic [`RVFI_XLEN-1:0]    instr;
  } sb_entry_t;

  typedef struct packed {
    logic                           valid;
    logic [`RVFI_XLEN-1:0]          insn;
    logic                           trap;
    logic [`RVFI_XLEN-1:0]          cause;
    logic [1:0]                     mode;     // 2 encodes debug mode
    logic [1:0]                     ixl;
    logic [`RVFI_REG_ADDR_BITS-1:0] rs1_addr;
    logic [`RVFI_REG_ADDR_BITS-1:0] rs2_addr;
    logic [`RVFI_REG_ADDR_BITS-1:0] rd_addr;
    logic [`RVFI_XLEN-1:0]          rd_wdata;
    logic [`RVFI_VLEN-1:0]          pc_rdata;
    logic [`RVFI_VLEN-1:0]          mem_addr;
    logic [`RVFI_BE_BITS-1:0]       mem_rmask;
    logic [`RVFI_BE_BITS-1:0]       mem_wmask;
    logic [`RVFI_XLEN-1:0]          mem_wdata;
    logic [`RVFI_XLEN-1:0]          mem_rdata;
    logic [`RVFI_XLEN-1:0]          rs1_rdata;
    logic [`RVFI_XLEN-1:0]          rs2_rdata;
  } rvfi_instr_t;

endpackage

// File: rvfi_issue_capture.sv
/*
  RVFI decode stage capture
  Mirrors the core's one-entry decode slot, holding the instruction
  word that goes out with the next issue. Compressed words are
  stored zero-extended
*/

`timescale 1ns/1ps

`include "rvfi_params.svh"

module rvfi_issue_capture
  import rvfi_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  fetch_probe_t          fetch_i,
  input  logic                  issue_instr_ack_i,
  input  logic                  flush_i,
  output logic [`RVFI_XLEN-1:0] issue_instr_o
);

  slot_state_e           state_q;
  slot_state_e           state_d;
  logic [`RVFI_XLEN-1:0] instr_q;
  logic [`RVFI_XLEN-1:0] instr_d;
  logic                  fetch_take;

  // Slot free now or freed by the issue in this cycle
  assign fetch_take = fetch_i.valid && ((state_q == SLOT_EMPTY) || issue_instr_ack_i);

  always_comb begin
    state_d = state_q;
    instr_d = instr_q;
    if (issue_instr_ack_i) begin
      state_d = SLOT_EMPTY;
    end
    if (flush_i) begin
      state_d = SLOT_EMPTY;  // Flush beats a fetch
    end else if (fetch_take) begin
      state_d = SLOT_FULL;
      instr_d = fetch_i.is_compressed ?
                {{(`RVFI_XLEN-16){1'b0}}, fetch_i.instr[15:0]} : fetch_i.instr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SLOT_EMPTY;
      instr_q <= '0;
    end else begin
      state_q <= state_d;
      instr_q <= instr_d;
    end
  end

  assign issue_instr_o = instr_q;

  // ------------------------------
  // Checks
  // ------------------------------
  // The core only issues what decode already holds
  a_ack_needs_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue_instr_ack_i |-> (state_q == SLOT_FULL)
  ) else $error("issue ack seen while the decode slot is empty");

endmodule

// File: rvfi_sb_tracker.sv
/*
  RVFI scoreboard side table
  One entry per scoreboard slot, written with operands and the
  instruction at issue and annotated with address, masks and store
  data when the LSU reports the transaction. Read at commit pointers
*/

`timescale 1ns/1ps

`include "rvfi_params.svh"

module rvfi_sb_tracker
  import rvfi_pkg::*;
(
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  issue_probe_t                                              issue_i,
  input  logic [`RVFI_XLEN-1:0]                                     issue_instr_i,
  input  lsu_probe_t                                                lsu_i,
  input  logic [`RVFI_NR_COMMIT_PORTS-1:0][`RVFI_TRANS_ID_BITS-1:0] commit_ptr_i,
  output sb_entry_t [`RVFI_NR_COMMIT_PORTS-1:0]                     entry_o
);

  sb_entry_t [`RVFI_NR_SB_ENTRIES-1:0] mem_q;
  sb_entry_t [`RVFI_NR_SB_ENTRIES-1:0] mem_n;

  logic [`RVFI_BE_BITS-1:0] lsu_rmask;
  logic [`RVFI_BE_BITS-1:0] lsu_wmask;
  logic                     issue_write;

  // ------------------------------
  // Mask derivation
  // ------------------------------
  assign lsu_rmask = (lsu_i.fu == FU_LOAD)  ? lsu_i.be : '0;
  assign lsu_wmask = (lsu_i.fu == FU_STORE) ? lsu_i.be : '0;

  assign issue_write = issue_i.decoded_valid && issue_i.decoded_ack &&
                       !issue_i.flush_unissued;

  // ------------------------------
  // Table update
  // ------------------------------
  always_comb begin
    mem_n = mem_q;

    // New issue starts with empty memory fields
    if (issue_write) begin
      mem_n[issue_i.issue_ptr] = '{
        rs1_rdata: issue_i.rs1_fwd,
        rs2_rdata: issue_i.rs2_fwd,
        mem_addr:  '0,
        mem_rmask: '0,
        mem_wmask: '0,
        mem_wdata: '0,
        instr:     issue_instr_i
      };
    end

    // LSU annotation last, so it wins on a same-cycle issue
    if (lsu_rmask != '0) begin
      mem_n[lsu_i.trans_id].mem_addr  = lsu_i.vaddr;
      mem_n[lsu_i.trans_id].mem_rmask = lsu_rmask;
    end else if (lsu_wmask != '0) begin
      mem_n[lsu_i.trans_id].mem_addr  = lsu_i.vaddr;
      mem_n[lsu_i.trans_id].mem_wmask = lsu_wmask;
      mem_n[lsu_i.trans_id].mem_wdata = lsu_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_n;
    end
  end

  // ------------------------------
  // Commit side read
  // ------------------------------
  always_comb begin
    for (int p = 0; p < `RVFI_NR_COMMIT_PORTS; p++) begin
      entry_o[p] = mem_q[commit_ptr_i[p]];  // Pointer from the core's commit stage
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  // A transaction is either a load or a store, never both over its lifetime
  for (genvar g = 0; g < `RVFI_NR_SB_ENTRIES; g++) begin : g_mask_chk
    a_mask_excl : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      !((mem_q[g].mem_rmask != '0) && (mem_q[g].mem_wmask != '0))
    ) else $error("table entry holds both a read mask and a write mask");
  end

endmodule

// File: rvfi_commit_pack.sv
/*
  RVFI commit packer
  Combines the commit and trap probes with the side table entry of
  each commit port into one retirement record, with no latency
*/

`timescale 1ns/1ps

`include "rvfi_params.svh"

module rvfi_commit_pack
  import rvfi_pkg::*;
(
  input  commit_probe_t [`RVFI_NR_COMMIT_PORTS-1:0] commit_i,
  input  trap_probe_t                               trap_i,
  input  priv_lvl_e                                 priv_lvl_i,
  input  logic                                      debug_mode_i,
  input  sb_entry_t [`RVFI_NR_COMMIT_PORTS-1:0]     entry_i,
  output rvfi_instr_t [`RVFI_NR_COMMIT_PORTS-1:0]   rvfi_o
);

  localparam logic [1:0] ModeDebug = 2'd2;
  localparam logic [1:0] Xlen32    = 2'd1;  // MXL encoding for RV32

  logic       is_ecall;
  logic [1:0] mode;

  // ------------------------------
  // Shared over all ports
  // ------------------------------
  assign is_ecall = (trap_i.cause == `RVFI_CAUSE_ECALL_U) ||
                    (trap_i.cause == `RVFI_CAUSE_ECALL_S) ||
                    (trap_i.cause == `RVFI_CAUSE_ECALL_M);

  assign mode = debug_mode_i ? ModeDebug : priv_lvl_i;

  // ------------------------------
  // Record per port
  // ------------------------------
  always_comb begin
    for (int p = 0; p < `RVFI_NR_COMMIT_PORTS; p++) begin
      rvfi_o[p].trap  = commit_i[p].valid && trap_i.valid;
      // An ecall traps but still counts as retired
      rvfi_o[p].valid = (commit_i[p].ack && !trap_i.valid) ||
                        (commit_i[p].valid && trap_i.valid && is_ecall);
      rvfi_o[p].insn  = entry_i[p].instr;
      rvfi_o[p].cause = trap_i.cause;
      rvfi_o[p].mode  = mode;
      rvfi_o[p].ixl   = Xlen32;

      rvfi_o[p].rs1_addr = commit_i[p].rs1;
      rvfi_o[p].rs2_addr = commit_i[p].rs2;
      rvfi_o[p].rd_addr  = commit_i[p].rd;
      rvfi_o[p].rd_wdata = commit_i[p].wdata;
      rvfi_o[p].pc_rdata = commit_i[p].pc;

      rvfi_o[p].mem_addr  = entry_i[p].mem_addr;
      rvfi_o[p].mem_rmask = entry_i[p].mem_rmask;
      rvfi_o[p].mem_wmask = entry_i[p].mem_wmask;
      rvfi_o[p].mem_wdata = entry_i[p].mem_wdata;
      rvfi_o[p].mem_rdata = commit_i[p].result;  // Load data is the FU result

      rvfi_o[p].rs1_rdata = entry_i[p].rs1_rdata;  // Operands as seen at issue
      rvfi_o[p].rs2_rdata = entry_i[p].rs2_rdata;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  // The core acknowledges only a commit it has presented
  always_comb begin
    for (int p = 0; p < `RVFI_NR_COMMIT_PORTS; p++) begin
      a_ack_needs_valid : assert final (!commit_i[p].ack || commit_i[p].valid)
        else $error("commit ack without commit valid on a port");
    end
  end

endmodule

// File: rvfi_tracer.sv
/*
  RVFI instruction tracer
  Observes decode, issue, LSU and commit probes of a two-port core
  and reports one retirement record per commit port
*/

`timescale 1ns/1ps

`include "rvfi_params.svh"

module rvfi_tracer
  import rvfi_pkg::*;
(
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  fetch_probe_t                              fetch_i,
  input  issue_probe_t                              issue_i,
  input  lsu_probe_t                                lsu_i,
  input  commit_probe_t [`RVFI_NR_COMMIT_PORTS-1:0] commit_i,
  input  trap_probe_t                               trap_i,
  input  priv_lvl_e                                 priv_lvl_i,
  input  logic                                      debug_mode_i,
  output rvfi_instr_t [`RVFI_NR_COMMIT_PORTS-1:0]   rvfi_o
);

  logic [`RVFI_XLEN-1:0]                                     issue_instr;
  logic [`RVFI_NR_COMMIT_PORTS-1:0][`RVFI_TRANS_ID_BITS-1:0] commit_ptr;
  sb_entry_t [`RVFI_NR_COMMIT_PORTS-1:0]                     entry;

  for (genvar p = 0; p < `RVFI_NR_COMMIT_PORTS; p++) begin : g_ptr
    assign commit_ptr[p] = commit_i[p].ptr;
  end

  // Decode
  rvfi_issue_capture i_capture (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fetch_i           (fetch_i),
    .issue_instr_ack_i (issue_i.issue_instr_ack),
    .flush_i           (issue_i.flush),
    .issue_instr_o     (issue_instr)
  );

  // Execute
  rvfi_sb_tracker i_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_i       (issue_i),
    .issue_instr_i (issue_instr),
    .lsu_i         (lsu_i),
    .commit_ptr_i  (commit_ptr),
    .entry_o       (entry)
  );

  // Result
  rvfi_commit_pack i_pack (
    .commit_i     (commit_i),
    .trap_i       (trap_i),
    .priv_lvl_i   (priv_lvl_i),
    .debug_mode_i (debug_mode_i),
    .entry_i      (entry),
    .rvfi_o       (rvfi_o)
  );

endmodule

// File: tb_clk_gen.sv
/*
  Testbench clock and reset
  Free-running 4 ns clock with an active low reset held for a
  number of cycles after start
*/

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned RstCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: tb_rvfi_tracer.sv
/*
  RVFI tracer testbench
  Drives fetch, issue, LSU, commit and trap probes, mirrors the
  capture slot and side table in a model and compares every record
*/

`timescale 1ns/1ps

`include "rvfi_params.svh"

module tb_rvfi_tracer
  import rvfi_pkg::*;
();

  logic                                      clk;
  logic                                      rst_n;
  fetch_probe_t                              fetch;
  issue_probe_t                              issue;
  lsu_probe_t                                lsu;
  commit_probe_t [`RVFI_NR_COMMIT_PORTS-1:0] commit;
  trap_probe_t                               trap;
  priv_lvl_e                                 priv_lvl;
  logic                                      debug_mode;
  rvfi_instr_t [`RVFI_NR_COMMIT_PORTS-1:0]   rvfi;

  slot_state_e           m_slot;
  logic [`RVFI_XLEN-1:0] m_word;
  sb_entry_t             m_table [`RVFI_NR_SB_ENTRIES];
  logic [31:0]           lfsr;
  string                 test_name;

  tb_clk_gen #(.RstCycles(16)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  rvfi_tracer i_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .fetch_i      (fetch),
    .issue_i      (issue),
    .lsu_i        (lsu),
    .commit_i     (commit),
    .trap_i       (trap),
    .priv_lvl_i   (priv_lvl),
    .debug_mode_i (debug_mode),
    .rvfi_o       (rvfi)
  );

  // ------------------------------
  // Random source and reference
  // ------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic rvfi_instr_t ref_record(input commit_probe_t c, input trap_probe_t t,
                                             input priv_lvl_e pl, input logic dbg,
                                             input sb_entry_t e);
    rvfi_instr_t r;
    logic        ecall;
    ecall = (t.cause == 32'd8) || (t.cause == 32'd9) || (t.cause == 32'd11);
    r.trap = c.valid && t.valid;
    r.valid = (c.ack && !t.valid) || (r.trap && ecall);
    r.insn = e.instr;
    r.cause = t.cause;
    r.mode = dbg ? 2'd2 : pl;
    r.ixl = 2'd1;
    r.rs1_addr = c.rs1;
    r.rs2_addr = c.rs2;
    r.rd_addr = c.rd;
    r.rd_wdata = c.wdata;
    r.pc_rdata = c.pc;
    r.mem_addr = e.mem_addr;
    r.mem_rmask = e.mem_rmask;
    r.mem_wmask = e.mem_wmask;
    r.mem_wdata = e.mem_wdata;
    r.mem_rdata = c.result;
    r.rs1_rdata = e.rs1_rdata;
    r.rs2_rdata = e.rs2_rdata;
    return r;
  endfunction

  // Capture slot and side table as seen by the core's handshakes
  always @(posedge clk or negedge rst_n) begin : model
    sb_entry_t nxt [`RVFI_NR_SB_ENTRIES];
    if (!rst_n) begin
      m_slot <= SLOT_EMPTY;
      m_word <= '0;
      for (int i = 0; i < `RVFI_NR_SB_ENTRIES; i++) begin
        m_table[i] <= '0;
      end
    end else begin
      if (issue.flush) begin
        m_slot <= SLOT_EMPTY;
      end else if (fetch.valid && (m_slot == SLOT_EMPTY || issue.issue_instr_ack)) begin
        m_slot <= SLOT_FULL;
        m_word <= fetch.is_compressed ? {16'h0, fetch.instr[15:0]} : fetch.instr;
      end else if (issue.issue_instr_ack) begin
        m_slot <= SLOT_EMPTY;
      end
      nxt = m_table;
      if (issue.decoded_valid && issue.decoded_ack && !issue.flush_unissued) begin
        nxt[issue.issue_ptr] = '0;
        nxt[issue.issue_ptr].rs1_rdata = issue.rs1_fwd;
        nxt[issue.issue_ptr].rs2_rdata = issue.rs2_fwd;
        nxt[issue.issue_ptr].instr = m_word;
      end
      if (lsu.be != '0 && lsu.fu == FU_LOAD) begin
        nxt[lsu.trans_id].mem_addr = lsu.vaddr;
        nxt[lsu.trans_id].mem_rmask = lsu.be;
      end else if (lsu.be != '0 && lsu.fu == FU_STORE) begin
        nxt[lsu.trans_id].mem_addr = lsu.vaddr;
        nxt[lsu.trans_id].mem_wmask = lsu.be;
        nxt[lsu.trans_id].mem_wdata = lsu.wdata;
      end
      m_table <= nxt;
    end
  end

  // ------------------------------
  // Compare
  // ------------------------------
  task automatic check_record(input string name, input rvfi_instr_t exp,
                              input rvfi_instr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "record mismatch");
    end
  endtask

  task automatic check_mode(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected mode %h actual mode %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "mode mismatch");
    end
  endtask

  task automatic compare_port(input logic port);
    rvfi_instr_t exp;
    exp = ref_record(commit[port], trap, priv_lvl, debug_mode, m_table[commit[port].ptr]);
    check_mode(test_name, exp.mode, rvfi[port].mode);
    check_record(test_name, exp, rvfi[port]);
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      compare_port(1'b0);
      compare_port(1'b1);
    end
  end

  // Reference record with the hand-derived fields forced in
  task automatic check_commit(input string name, input logic port, input logic [31:0] insn,
                              input logic [3:0] rmask, input logic [3:0] wmask,
                              input logic valid, input logic trap_exp);
    rvfi_instr_t exp;
    exp = ref_record(commit[port], trap, priv_lvl, debug_mode, m_table[commit[port].ptr]);
    exp.insn = insn;
    exp.mem_rmask = rmask;
    exp.mem_wmask = wmask;
    exp.valid = valid;
    exp.trap = trap_exp;
    check_record(name, exp, rvfi[port]);
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic wait_reset();
    int n;
    n = 0;
    while (!rst_n) begin
      n++;
      if (n > 100) begin
        $display("reset was never released");
        $display("TEST FAIL");
        $fatal(1, "reset timeout");
      end
      @(posedge clk);
    end
  endtask

  task automatic wait_valid(input logic port);
    int n;
    n = 0;
    @(negedge clk);
    while (!rvfi[port].valid) begin
      n++;
      if (n > 8) begin
        $display("retirement record never became valid on port %0d", port);
        $display("TEST FAIL");
        $fatal(1, "valid timeout");
      end
      @(negedge clk);
    end
  endtask

  // One fetch, then its issue into ptr with random operands
  task automatic fetch_issue(input logic [31:0] word, input logic comp, input logic [2:0] ptr,
                             input logic flush_un);
    logic [31:0] rs1;
    logic [31:0] rs2;
    rand_bits(32, rs1);
    rand_bits(32, rs2);
    @(posedge clk);
    fetch <= '{valid: 1'b1, instr: word, is_compressed: comp};
    @(posedge clk);
    fetch.valid <= 1'b0;
    issue <= '{decoded_valid: 1'b1, decoded_ack: 1'b1, flush_unissued: flush_un,
               issue_ptr: ptr, issue_instr_ack: 1'b1, flush: 1'b0, rs1_fwd: rs1, rs2_fwd: rs2};
    @(posedge clk);
    issue <= '0;
  endtask

  task automatic lsu_report(input fu_e fu, input logic [2:0] id, input logic [3:0] be);
    logic [31:0] addr;
    logic [31:0] data;
    rand_bits(32, addr);
    rand_bits(32, data);
    @(posedge clk);
    lsu <= '{fu: fu, vaddr: addr, be: be, trans_id: id, wdata: data};
    @(posedge clk);
    lsu <= '0;
  endtask

  // Called right after a rising edge
  task automatic commit_drive(input logic port, input logic [2:0] ptr, input logic trap_v,
                              input logic [31:0] cause);
    commit_probe_t c;
    logic [31:0]   v;
    c.valid = 1'b1;
    c.ack = 1'b1;
    c.ptr = ptr;
    rand_bits(32, v);
    c.pc = v;
    rand_bits(15, v);
    c.rs1 = v[4:0];
    c.rs2 = v[9:5];
    c.rd = v[14:10];
    rand_bits(32, v);
    c.result = v;
    rand_bits(32, v);
    c.wdata = v;
    commit[port] <= c;
    trap <= '{valid: trap_v, cause: cause};
  endtask

  task automatic commit_release();
    @(posedge clk);
    commit <= '0;
    trap <= '0;
  endtask

  initial begin : watchdog
    #20us;
    $display("simulation ran past its time limit");
    $display("TEST FAIL");
    $fatal(1, "watchdog");
  end

  initial begin : stimulus
    logic [31:0] v;
    logic [31:0] words [4];
    logic [2:0]  ptrs [4];
    logic [3:0]  be;
    fetch = '0;
    issue = '0;
    lsu = '0;
    commit = '0;
    trap = '0;
    priv_lvl = PRIV_M;
    debug_mode = 1'b0;
    lfsr = 32'd74522;
    test_name = "reset";
    wait_reset();
    @(negedge clk);
    check_commit(test_name, 1'b0, 32'h0, 4'h0, 4'h0, 1'b0, 1'b0);
    check_commit(test_name, 1'b1, 32'h0, 4'h0, 4'h0, 1'b0, 1'b0);

    test_name = "compressed fetch";
    rand_bits(32, v);
    v[31] = 1'b1;  // Upper half must be dropped
    fetch_issue(v, 1'b1, 3'd1, 1'b0);
    @(posedge clk);
    commit_drive(1'b0, 3'd1, 1'b0, 32'd0);
    wait_valid(1'b0);
    check_commit(test_name, 1'b0, {16'h0, v[15:0]}, 4'h0, 4'h0, 1'b1, 1'b0);
    commit_release();
    test_name = "full fetch";
    rand_bits(32, v);
    fetch_issue(v, 1'b0, 3'd2, 1'b0);
    @(posedge clk);
    commit_drive(1'b1, 3'd2, 1'b0, 32'd0);
    wait_valid(1'b1);
    check_commit(test_name, 1'b1, v, 4'h0, 4'h0, 1'b1, 1'b0);
    commit_release();

    // Four entries in flight, then retired two per cycle
    test_name = "outstanding operands";
    rand_bits(3, v);
    for (int k = 0; k < 4; k++) begin
      ptrs[k] = v[2:0] + 3'(k);
    end
    for (int k = 0; k < 4; k++) begin
      rand_bits(32, words[k]);
      fetch_issue(words[k], 1'b0, ptrs[k], 1'b0);
    end
    for (int k = 0; k < 4; k += 2) begin
      @(posedge clk);
      commit_drive(1'b0, ptrs[k], 1'b0, 32'd0);
      commit_drive(1'b1, ptrs[k+1], 1'b0, 32'd0);
      wait_valid(1'b0);
      check_commit(test_name, 1'b0, words[k], 4'h0, 4'h0, 1'b1, 1'b0);
      check_commit(test_name, 1'b1, words[k+1], 4'h0, 4'h0, 1'b1, 1'b0);
      commit_release();
    end

    test_name = "load annotation";
    rand_bits(4, v);
    be = v[3:0] | 4'h1;
    rand_bits(32, words[0]);
    fetch_issue(words[0], 1'b0, 3'd5, 1'b0);
    lsu_report(FU_LOAD, 3'd5, be);
    @(posedge clk);
    commit_drive(1'b1, 3'd5, 1'b0, 32'd0);
    wait_valid(1'b1);
    check_commit(test_name, 1'b1, words[0], be, 4'h0, 1'b1, 1'b0);
    commit_release();
    test_name = "store annotation";
    rand_bits(4, v);
    be = v[3:0] | 4'h8;
    rand_bits(32, words[1]);
    fetch_issue(words[1], 1'b0, 3'd6, 1'b0);
    lsu_report(FU_STORE, 3'd6, be);
    @(posedge clk);
    commit_drive(1'b0, 3'd6, 1'b0, 32'd0);
    wait_valid(1'b0);
    check_commit(test_name, 1'b0, words[1], 4'h0, be, 1'b1, 1'b0);
    commit_release();

    // Reissue into the loaded entry, its memory fields must come back empty
    test_name = "ecall trap";
    rand_bits(32, words[2]);
    fetch_issue(words[2], 1'b0, 3'd5, 1'b0);
    @(posedge clk);
    commit_drive(1'b0, 3'd5, 1'b1, `RVFI_CAUSE_ECALL_M);
    wait_valid(1'b0);
    check_commit(test_name, 1'b0, words[2], 4'h0, 4'h0, 1'b1, 1'b1);
    commit_release();
    test_name = "other trap";
    @(posedge clk);
    commit_drive(1'b0, 3'd5, 1'b1, 32'd2);  // Illegal instruction
    @(negedge clk);
    check_commit(test_name, 1'b0, words[2], 4'h0, 4'h0, 1'b0, 1'b1);
    commit_release();

    test_name = "debug mode";
    @(posedge clk);
    debug_mode <= 1'b1;
    @(negedge clk);
    check_mode(test_name, 2'd2, rvfi[0].mode);
    test_name = "user mode";
    @(posedge clk);
    debug_mode <= 1'b0;
    priv_lvl <= PRIV_U;
    @(negedge clk);
    check_mode(test_name, 2'd0, rvfi[1].mode);

    // Second issue is dropped so the first one stays in the entry
    test_name = "flush unissued";
    rand_bits(32, words[3]);
    fetch_issue(words[3], 1'b0, 3'd7, 1'b0);
    rand_bits(32, v);
    fetch_issue(v, 1'b0, 3'd7, 1'b1);
    @(posedge clk);
    commit_drive(1'b1, 3'd7, 1'b0, 32'd0);
    wait_valid(1'b1);
    check_commit(test_name, 1'b1, words[3], 4'h0, 4'h0, 1'b1, 1'b0);
    commit_release();

    repeat (2) @(posedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: rvfi_tracer.f
+incdir+.
rvfi_pkg.sv
rvfi_issue_capture.sv
rvfi_sb_tracker.sv
rvfi_commit_pack.sv
rvfi_tracer.sv
tb_clk_gen.sv
tb_rvfi_tracer.sv

// File: Makefile
# Verilator flow for the RVFI tracer

TOP := tb_rvfi_tracer
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f rvfi_tracer.f --top-module rvfi_tracer
	verilator --lint-only --timing --assert -f rvfi_tracer.f --top-module $(TOP)

# The run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -j 0 -f rvfi_tracer.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
